// ==== autofire.sv ====
// autofire for one button
// while held, the output toggles every AUTOFIRE_HALF_PERIOD cycles

`timescale 1ns/1ps

module autofire
    import pad_pkg::*;
(
    input  logic clk,
    input  logic i_sys_resetn,
    input  logic i_btn,
    output logic o_fire
);

    logic [AF_CNT_W-1:0] half_cnt;

    always_ff @(posedge clk) begin
        if (!i_sys_resetn || !i_btn) begin   // release restarts the pattern
            half_cnt <= '0;
            o_fire   <= 1'b0;
        end else begin
            if (half_cnt == '0)
                o_fire <= ~o_fire;          // first held cycle fires at once
            if (int'(half_cnt) == AUTOFIRE_HALF_PERIOD - 1)
                half_cnt <= '0;
            else
                half_cnt <= half_cnt + 1'b1;
        end
    end

endmodule

// ==== joypad_shifter.sv ====
// nes joypad port as seen by the console core
// strobe latches the buttons, each falling joypad clock shifts one out
// o_data is register bit 0, zeros fill from the top

`timescale 1ns/1ps

module joypad_shifter
    import pad_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_sys_resetn,
    input  logic [NES_BTN_W-1:0] i_btn,
    input  logic                 i_strobe,
    input  logic                 i_joy_clk,
    output logic                 o_data
);

    logic                 joy_clk_q;     // registered joypad clock
    logic                 joy_clk_prev;  // last cycle's registered value
    logic                 joy_clk_fall;
    logic [NES_BTN_W-1:0] shift_reg;

    assign joy_clk_fall = joy_clk_prev & ~joy_clk_q;

    always_ff @(posedge clk) begin
        if (!i_sys_resetn) begin
            joy_clk_q    <= 1'b0;
            joy_clk_prev <= 1'b0;
            shift_reg    <= '0;
        end else begin
            joy_clk_q    <= i_joy_clk;
            joy_clk_prev <= joy_clk_q;
            // shift has priority over a strobe in the same cycle
            if (joy_clk_fall)
                shift_reg <= {1'b0, shift_reg[NES_BTN_W-1:1]};
            else if (i_strobe)
                shift_reg <= i_btn;
        end
    end

    assign o_data = shift_reg[0];

endmodule

// ==== pad_map.sv ====
// maps one player's controllers onto the eight nes buttons
// dualshock bytes are active low, usb buttons active high, results are ORed
// square and triangle drive autofire on B and A

`timescale 1ns/1ps

module pad_map
    import pad_pkg::*;
(
    input  logic                 clk,
    input  logic                 i_sys_resetn,
    input  logic [DS_BYTE_W-1:0] i_ds_rx0,
    input  logic [DS_BYTE_W-1:0] i_ds_rx1,
    input  logic [NES_BTN_W-1:0] i_usb_btn,
    input  logic                 i_usb_x,
    input  logic                 i_usb_y,
    output logic [NES_BTN_W-1:0] o_btn
);

    logic [NES_BTN_W-1:0] ds_btn;
    logic [NES_BTN_W-1:0] af_btn;
    logic                 af_a_in;
    logic                 af_b_in;
    logic                 fire_a;
    logic                 fire_b;

    assign af_a_in = ~i_ds_rx1[DS1_TRIANGLE] | i_usb_x;
    assign af_b_in = ~i_ds_rx1[DS1_SQUARE] | i_usb_y;

    autofire u_af_b (
        .clk          (clk),
        .i_sys_resetn (i_sys_resetn),
        .i_btn        (af_b_in),
        .o_fire       (fire_b)
    );

    autofire u_af_a (
        .clk          (clk),
        .i_sys_resetn (i_sys_resetn),
        .i_btn        (af_a_in),
        .o_fire       (fire_a)
    );

    ////////////////////////////////////////////////////////////
    // dualshock to nes order

    always_comb begin
        ds_btn = '0;
        ds_btn[BTN_A]      = ~i_ds_rx1[DS1_CIRCLE];
        ds_btn[BTN_B]      = ~i_ds_rx1[DS1_CROSS];
        ds_btn[BTN_SELECT] = ~i_ds_rx0[DS0_SELECT];
        ds_btn[BTN_START]  = ~i_ds_rx0[DS0_START];
        ds_btn[BTN_UP]     = ~i_ds_rx0[DS0_UP];
        ds_btn[BTN_DOWN]   = ~i_ds_rx0[DS0_DOWN];
        ds_btn[BTN_LEFT]   = ~i_ds_rx0[DS0_LEFT];
        ds_btn[BTN_RIGHT]  = ~i_ds_rx0[DS0_RIGHT];
    end

    always_comb begin
        af_btn = '0;
        af_btn[BTN_A] = fire_a;
        af_btn[BTN_B] = fire_b;
    end

    assign o_btn = ds_btn | af_btn | i_usb_btn;

endmodule

// ==== pad_pkg.sv ====
// shared definitions for the controller input path
// nes button order, dualshock byte layout, reset and autofire timing
// imported by every module of the pad path and by the testbench

package pad_pkg;

    ////////////////////////////////////////////////////////////
    // nes side

    localparam int NES_BTN_W = 8;

    // bit positions in the joypad shift register, A comes out first
    typedef enum logic [2:0] {
        BTN_A      = 3'd0,
        BTN_B      = 3'd1,
        BTN_SELECT = 3'd2,
        BTN_START  = 3'd3,
        BTN_UP     = 3'd4,
        BTN_DOWN   = 3'd5,
        BTN_LEFT   = 3'd6,
        BTN_RIGHT  = 3'd7
    } nes_btn_e;

    ////////////////////////////////////////////////////////////
    // dualshock raw bytes, all bits active low

    localparam int DS_BYTE_W    = 8;

    localparam int DS0_SELECT   = 0;
    localparam int DS0_START    = 3;
    localparam int DS0_UP       = 4;
    localparam int DS0_RIGHT    = 5;
    localparam int DS0_DOWN     = 6;
    localparam int DS0_LEFT     = 7;

    localparam int DS1_TRIANGLE = 4;    // autofire A
    localparam int DS1_CIRCLE   = 5;    // A
    localparam int DS1_CROSS    = 6;    // B
    localparam int DS1_SQUARE   = 7;    // autofire B

    ////////////////////////////////////////////////////////////
    // timing

    localparam int RESET_HOLD_CYCLES    = 255;
    localparam int RESET_CNT_W          = $clog2(RESET_HOLD_CYCLES + 1);
    localparam int AUTOFIRE_HALF_PERIOD = 8;    // cycles per autofire level
    localparam int AF_CNT_W             = $clog2(AUTOFIRE_HALF_PERIOD);

    typedef enum logic {
        RST_HOLD,
        RST_RUN
    } rst_state_e;

endpackage

// ==== pad_top.sv ====
// controller input path of the console
// two players: dualshock bytes plus usb buttons in, nes joypad serial bits out
// also generates the system reset (power-up hold and home combo)

`timescale 1ns/1ps

module pad_top
    import pad_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,

    // player 1
    input  logic [DS_BYTE_W-1:0] i_ds_rx0_p1,
    input  logic [DS_BYTE_W-1:0] i_ds_rx1_p1,
    input  logic [NES_BTN_W-1:0] i_usb_btn_p1,
    input  logic                 i_usb_x_p1,
    input  logic                 i_usb_y_p1,

    // player 2
    input  logic [DS_BYTE_W-1:0] i_ds_rx0_p2,
    input  logic [DS_BYTE_W-1:0] i_ds_rx1_p2,
    input  logic [NES_BTN_W-1:0] i_usb_btn_p2,
    input  logic                 i_usb_x_p2,
    input  logic                 i_usb_y_p2,

    // console core joypad interface
    input  logic                 i_joy_strobe,
    input  logic [1:0]           i_joy_clk,     // one per port
    output logic [1:0]           o_joy_data,

    output logic                 o_sys_resetn
);

    logic [NES_BTN_W-1:0] btn_p1;
    logic [NES_BTN_W-1:0] btn_p2;
    logic                 sys_resetn;

    assign o_sys_resetn = sys_resetn;

    ////////////////////////////////////////////////////////////
    // button mapping

    pad_map u_map_p1 (
        .clk          (clk),
        .i_sys_resetn (sys_resetn),
        .i_ds_rx0     (i_ds_rx0_p1),
        .i_ds_rx1     (i_ds_rx1_p1),
        .i_usb_btn    (i_usb_btn_p1),
        .i_usb_x      (i_usb_x_p1),
        .i_usb_y      (i_usb_y_p1),
        .o_btn        (btn_p1)
    );

    pad_map u_map_p2 (
        .clk          (clk),
        .i_sys_resetn (sys_resetn),
        .i_ds_rx0     (i_ds_rx0_p2),
        .i_ds_rx1     (i_ds_rx1_p2),
        .i_usb_btn    (i_usb_btn_p2),
        .i_usb_x      (i_usb_x_p2),
        .i_usb_y      (i_usb_y_p2),
        .o_btn        (btn_p2)
    );

    ////////////////////////////////////////////////////////////
    // joypad ports and reset

    joypad_shifter u_shift_p1 (
        .clk          (clk),
        .i_sys_resetn (sys_resetn),
        .i_btn        (btn_p1),
        .i_strobe     (i_joy_strobe),
        .i_joy_clk    (i_joy_clk[0]),
        .o_data       (o_joy_data[0])
    );

    joypad_shifter u_shift_p2 (
        .clk          (clk),
        .i_sys_resetn (sys_resetn),
        .i_btn        (btn_p2),
        .i_strobe     (i_joy_strobe),
        .i_joy_clk    (i_joy_clk[1]),
        .o_data       (o_joy_data[1])
    );

    reset_ctrl u_reset_ctrl (
        .clk          (clk),
        .resetn       (resetn),
        .i_btn_p1     (btn_p1),
        .o_sys_resetn (sys_resetn)
    );

endmodule

// ==== pad_top_properties.sv ====
// concurrent checks on the system reset and the joypad outputs
// bound into every pad_top instance by the bind at the end of this file

`timescale 1ns/1ps

module pad_top_properties
    import pad_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    input  logic       i_joy_strobe,
    input  logic [1:0] i_joy_clk,
    input  logic [1:0] i_joy_data,
    input  logic       i_sys_resetn
);

    int         run_cnt;        // cycles since resetn rose, saturates
    logic [1:0] joy_clk_q;
    logic [1:0] joy_clk_prev;
    logic [1:0] joy_fall;
    int         fall_cnt [2];   // falling joypad clocks since the last strobe

    assign joy_fall = joy_clk_prev & ~joy_clk_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            run_cnt      <= 0;
            joy_clk_q    <= '0;
            joy_clk_prev <= '0;
            fall_cnt[0]  <= 0;
            fall_cnt[1]  <= 0;
        end else begin
            if (run_cnt < RESET_HOLD_CYCLES)
                run_cnt <= run_cnt + 1;
            joy_clk_q    <= i_joy_clk;
            joy_clk_prev <= joy_clk_q;
            for (int p = 0; p < 2; p++) begin
                if (i_joy_strobe)
                    fall_cnt[p] <= 0;
                else if (joy_fall[p] && fall_cnt[p] < NES_BTN_W)
                    fall_cnt[p] <= fall_cnt[p] + 1;
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // reset

    hold_low: assert property (@(posedge clk) disable iff (!resetn)
        run_cnt < RESET_HOLD_CYCLES |-> !i_sys_resetn)
        else $error("system reset released before the hold count ran out");

    data_zero_in_reset: assert property (@(posedge clk) disable iff (!resetn)
        !i_sys_resetn |=> i_joy_data == 2'b00)
        else $error("joypad data not cleared by the system reset");

    ////////////////////////////////////////////////////////////
    // joypad ports, empty once all eight buttons are out

    port0_empty: assert property (@(posedge clk) disable iff (!resetn)
        fall_cnt[0] == NES_BTN_W |-> i_joy_data[0] == 1'b0)
        else $error("port 0 data not zero after eight joypad clocks");

    port1_empty: assert property (@(posedge clk) disable iff (!resetn)
        fall_cnt[1] == NES_BTN_W |-> i_joy_data[1] == 1'b0)
        else $error("port 1 data not zero after eight joypad clocks");

endmodule

bind pad_top pad_top_properties u_properties (
    .clk          (clk),
    .resetn       (resetn),
    .i_joy_strobe (i_joy_strobe),
    .i_joy_clk    (i_joy_clk),
    .i_joy_data   (o_joy_data),
    .i_sys_resetn (o_sys_resetn)
);

// ==== reset_ctrl.sv ====
// system reset generation
// holds reset after power-up, then follows the home combo on player 1

`timescale 1ns/1ps

module reset_ctrl
    import pad_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic [NES_BTN_W-1:0] i_btn_p1,
    output logic                 o_sys_resetn
);

    rst_state_e             state;
    logic [RESET_CNT_W-1:0] hold_cnt;
    logic                   home_combo;

    // home button shows up as select + down
    assign home_combo = i_btn_p1[BTN_SELECT] & i_btn_p1[BTN_DOWN];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state        <= RST_HOLD;
            hold_cnt     <= RESET_CNT_W'(RESET_HOLD_CYCLES);
            o_sys_resetn <= 1'b0;
        end else begin
            case (state)
                RST_HOLD: begin
                    o_sys_resetn <= 1'b0;
                    hold_cnt     <= hold_cnt - 1'b1;
                    if (hold_cnt == RESET_CNT_W'(1)) begin  // last hold cycle
                        state        <= RST_RUN;
                        o_sys_resetn <= ~home_combo;
                    end
                end
                RST_RUN:  o_sys_resetn <= ~home_combo;
                default:  state <= RST_HOLD;
            endcase
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
# build and run the pad_top testbench with verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f --top-module tb_pad_top
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit $status
fi

./obj_dir/Vtb_pad_top
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit $status
fi

exit 0

// ==== sources.f ====
pad_pkg.sv
autofire.sv
pad_map.sv
joypad_shifter.sv
reset_ctrl.sv
pad_top.sv
tb_clock.sv
pad_top_properties.sv
tb_pad_top.sv

// ==== tb_clock.sv ====
// clock source for the pad_top testbench
// free running, starts low

`timescale 1ns/1ps

module tb_clock (
    output logic o_clk
);

    initial o_clk = 1'b0;

    always #20 o_clk = ~o_clk;  // 40 ns period

endmodule

// ==== tb_pad_top.sv ====
// testbench for the controller input path
// applies a table of controller states and reads both joypad ports back serially,
// then checks autofire on A and B and the home combo reset

`timescale 1ns/1ps

module tb_pad_top
    import pad_pkg::*;
();

    localparam int N_RANDOM   = 6;
    localparam int AF_TIMEOUT = 4 * AUTOFIRE_HALF_PERIOD;

    typedef struct packed {
        logic [DS_BYTE_W-1:0] ds0_p1;
        logic [DS_BYTE_W-1:0] ds1_p1;
        logic [NES_BTN_W-1:0] usb_p1;
        logic                 x_p1;
        logic                 y_p1;
        logic [DS_BYTE_W-1:0] ds0_p2;
        logic [DS_BYTE_W-1:0] ds1_p2;
        logic [NES_BTN_W-1:0] usb_p2;
        logic                 x_p2;
        logic                 y_p2;
        logic [NES_BTN_W-1:0] exp_p1;   // read order A first
        logic [NES_BTN_W-1:0] exp_p2;
        logic                 autofire;
    } entry_t;

    logic                 clk;
    logic                 resetn;
    logic [DS_BYTE_W-1:0] ds_rx0_p1;
    logic [DS_BYTE_W-1:0] ds_rx1_p1;
    logic [NES_BTN_W-1:0] usb_btn_p1;
    logic                 usb_x_p1;
    logic                 usb_y_p1;
    logic [DS_BYTE_W-1:0] ds_rx0_p2;
    logic [DS_BYTE_W-1:0] ds_rx1_p2;
    logic [NES_BTN_W-1:0] usb_btn_p2;
    logic                 usb_x_p2;
    logic                 usb_y_p2;
    logic                 joy_strobe;
    logic [1:0]           joy_clk;
    logic [1:0]           joy_data;
    logic                 sys_resetn;

    integer seed = 32'h4a6d;
    entry_t entries[$];

    tb_clock u_clock (.o_clk(clk));

    pad_top i_pad_top (
        .clk          (clk),
        .resetn       (resetn),
        .i_ds_rx0_p1  (ds_rx0_p1),
        .i_ds_rx1_p1  (ds_rx1_p1),
        .i_usb_btn_p1 (usb_btn_p1),
        .i_usb_x_p1   (usb_x_p1),
        .i_usb_y_p1   (usb_y_p1),
        .i_ds_rx0_p2  (ds_rx0_p2),
        .i_ds_rx1_p2  (ds_rx1_p2),
        .i_usb_btn_p2 (usb_btn_p2),
        .i_usb_x_p2   (usb_x_p2),
        .i_usb_y_p2   (usb_y_p2),
        .i_joy_strobe (joy_strobe),
        .i_joy_clk    (joy_clk),
        .o_joy_data   (joy_data),
        .o_sys_resetn (sys_resetn)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // nes buttons a player should show with autofire released
    function automatic logic [NES_BTN_W-1:0] expected_buttons(
        input logic [DS_BYTE_W-1:0] rx0,
        input logic [DS_BYTE_W-1:0] rx1,
        input logic [NES_BTN_W-1:0] usb
    );
        logic [NES_BTN_W-1:0] nes;
        nes = usb;
        if (rx1[DS1_CIRCLE] == 1'b0) nes[BTN_A] = 1'b1;
        if (rx1[DS1_CROSS] == 1'b0) nes[BTN_B] = 1'b1;
        if (rx0[DS0_SELECT] == 1'b0) nes[BTN_SELECT] = 1'b1;
        if (rx0[DS0_START] == 1'b0) nes[BTN_START] = 1'b1;
        if (rx0[DS0_UP] == 1'b0) nes[BTN_UP] = 1'b1;
        if (rx0[DS0_DOWN] == 1'b0) nes[BTN_DOWN] = 1'b1;
        if (rx0[DS0_LEFT] == 1'b0) nes[BTN_LEFT] = 1'b1;
        if (rx0[DS0_RIGHT] == 1'b0) nes[BTN_RIGHT] = 1'b1;
        return nes;
    endfunction

    function automatic entry_t make_entry(
        input logic [7:0] ds0_p1,
        input logic [7:0] ds1_p1,
        input logic [7:0] usb_p1,
        input logic       x_p1,
        input logic       y_p1,
        input logic [7:0] ds0_p2,
        input logic [7:0] ds1_p2,
        input logic [7:0] usb_p2,
        input logic       x_p2,
        input logic       y_p2,
        input logic       af
    );
        entry_t e;
        e = '{ds0_p1, ds1_p1, usb_p1, x_p1, y_p1, ds0_p2, ds1_p2, usb_p2, x_p2, y_p2,
              expected_buttons(ds0_p1, ds1_p1, usb_p1),
              expected_buttons(ds0_p2, ds1_p2, usb_p2), af};
        return e;
    endfunction

    ////////////////////////////////////////////////////////////
    // stimulus table

    task automatic build_table();
        logic [DS_BYTE_W-1:0] r0_p1;
        logic [DS_BYTE_W-1:0] r1_p1;
        logic [NES_BTN_W-1:0] ru_p1;
        logic [DS_BYTE_W-1:0] r0_p2;
        logic [DS_BYTE_W-1:0] r1_p2;
        logic [NES_BTN_W-1:0] ru_p2;
        logic [NES_BTN_W-1:0] mapped;
        // dualshock only
        entries.push_back(make_entry(8'hFF, 8'hFF, 8'h00, 0, 0, 8'hFF, 8'hFF, 8'h00, 0, 0, 0));
        entries.push_back(make_entry(8'hFF, 8'hDF, 8'h00, 0, 0, 8'hFF, 8'hBF, 8'h00, 0, 0, 0));
        entries.push_back(make_entry(8'hC7, 8'hFF, 8'h00, 0, 0, 8'h7E, 8'hFF, 8'h00, 0, 0, 0));
        entries.push_back(make_entry(8'h40, 8'h9F, 8'h00, 0, 0, 8'h00, 8'h9F, 8'h00, 0, 0, 0));
        // usb only and usb mixed with dualshock
        entries.push_back(make_entry(8'hFF, 8'hFF, 8'h81, 0, 0, 8'hFF, 8'hFF, 8'h5A, 0, 0, 0));
        entries.push_back(make_entry(8'hFF, 8'hBF, 8'h10, 0, 0, 8'h7F, 8'hBF, 8'h42, 0, 0, 0));
        for (int n = 0; n < N_RANDOM; n++) begin
            r0_p1 = 8'($random(seed));
            r1_p1 = 8'($random(seed));
            ru_p1 = 8'($random(seed));
            r0_p2 = 8'($random(seed));
            r1_p2 = 8'($random(seed));
            ru_p2 = 8'($random(seed));
            r1_p1[DS1_SQUARE]   = 1'b1;   // no autofire in read entries
            r1_p1[DS1_TRIANGLE] = 1'b1;
            r1_p2[DS1_SQUARE]   = 1'b1;
            r1_p2[DS1_TRIANGLE] = 1'b1;
            mapped = expected_buttons(r0_p1, r1_p1, ru_p1);
            if (mapped[BTN_SELECT] && mapped[BTN_DOWN]) begin   // keep clear of home
                r0_p1[DS0_DOWN] = 1'b1;
                ru_p1[BTN_DOWN] = 1'b0;
            end
            entries.push_back(make_entry(r0_p1, r1_p1, ru_p1, 0, 0,
                                         r0_p2, r1_p2, ru_p2, 0, 0, 0));
        end
        // autofire with square and triangle on one player and usb x and y on the other
        entries.push_back(make_entry(8'hFF, 8'h6F, 8'h00, 0, 0, 8'hFF, 8'hFF, 8'h00, 1, 1, 1));
        entries.push_back(make_entry(8'hFF, 8'hFF, 8'h00, 1, 1, 8'hFF, 8'h6F, 8'h00, 0, 0, 1));
    endtask

    task automatic release_all();
        ds_rx0_p1  = 8'hFF;
        ds_rx1_p1  = 8'hFF;
        usb_btn_p1 = '0;
        usb_x_p1   = 1'b0;
        usb_y_p1   = 1'b0;
        ds_rx0_p2  = 8'hFF;
        ds_rx1_p2  = 8'hFF;
        usb_btn_p2 = '0;
        usb_x_p2   = 1'b0;
        usb_y_p2   = 1'b0;
    endtask

    task automatic apply_entry(input entry_t e);
        ds_rx0_p1  = e.ds0_p1;
        ds_rx1_p1  = e.ds1_p1;
        usb_btn_p1 = e.usb_p1;
        usb_x_p1   = e.x_p1;
        usb_y_p1   = e.y_p1;
        ds_rx0_p2  = e.ds0_p2;
        ds_rx1_p2  = e.ds1_p2;
        usb_btn_p2 = e.usb_p2;
        usb_x_p2   = e.x_p2;
        usb_y_p2   = e.y_p2;
    endtask

    // one joypad clock pulse on both ports with data sampled after the shift
    task automatic shift_once(output logic [1:0] bits);
        joy_clk = 2'b11;
        @(negedge clk);
        joy_clk = 2'b00;
        repeat (2) @(negedge clk);
        bits = joy_data;
        @(negedge clk);
    endtask

    ////////////////////////////////////////////////////////////
    // checks

    task automatic check_reset_release();
        int cycles;
        assert (sys_resetn === 1'b0 && joy_data === 2'b00) else
            stop_with_failure($sformatf("** Error at %0d ns: after reset sys_resetn %b data %b",
                                        $time, sys_resetn, joy_data));
        cycles = 0;
        while (sys_resetn !== 1'b1 && cycles < RESET_HOLD_CYCLES + 10) begin
            @(negedge clk);
            cycles++;
        end
        assert (sys_resetn === 1'b1) else
            stop_with_failure("system reset was not released within the timeout");
    endtask

    task automatic read_ports(input entry_t e);
        logic [1:0] bits;
        logic [1:0] exp;
        joy_strobe = 1'b1;
        @(negedge clk);
        joy_strobe = 1'b0;
        @(negedge clk);
        bits = joy_data;
        for (int k = 0; k <= NES_BTN_W; k++) begin
            if (k > 0)
                shift_once(bits);
            exp = (k < NES_BTN_W) ? {e.exp_p2[k], e.exp_p1[k]} : 2'b00;
            assert (bits === exp) else
                stop_with_failure($sformatf("** Error at %0d ns: read %0d gave %b, expected %b",
                                            $time, k, bits, exp));
        end
    endtask

    task automatic check_autofire();
        logic [1:0] b_bits;
        logic [1:0] a_bits;
        logic [3:0] seen_hi;    // A of both ports above B of both ports
        logic [3:0] seen_lo;
        int         cycles;
        seen_hi    = 4'h0;
        seen_lo    = 4'h0;
        cycles     = 0;
        joy_strobe = 1'b1;     // reloads every cycle so a shift exposes B
        while ((seen_hi & seen_lo) != 4'hF && cycles < AF_TIMEOUT) begin
            shift_once(b_bits);
            a_bits  = joy_data;    // reloaded again after the shift
            seen_hi = seen_hi | {a_bits, b_bits};
            seen_lo = seen_lo | ~{a_bits, b_bits};
            cycles  = cycles + 4;
        end
        assert ((seen_hi & seen_lo) == 4'hF) else
            stop_with_failure("autofire on A and B did not toggle on both ports in time");
        release_all();
        shift_once(b_bits);      // B sampled 3 cycles after release
        a_bits = joy_data;
        assert ({a_bits, b_bits} === 4'h0) else
            stop_with_failure($sformatf("** Error at %0d ns: A %b B %b after release",
                                        $time, a_bits, b_bits));
        joy_strobe = 1'b0;
    endtask

    task automatic check_home_combo();
        int cycles;
        release_all();
        ds_rx0_p1[DS0_SELECT] = 1'b0;
        ds_rx0_p1[DS0_DOWN]   = 1'b0;
        ds_rx1_p1[DS1_CIRCLE] = 1'b0;
        joy_strobe            = 1'b1;
        cycles = 0;
        while (sys_resetn !== 1'b0 && cycles < 3) begin
            @(negedge clk);
            cycles++;
        end
        assert (sys_resetn === 1'b0) else
            stop_with_failure("home combo did not pull the system reset low within 3 cycles");
        @(negedge clk);
        assert (joy_data === 2'b00) else
            stop_with_failure($sformatf("** Error at %0d ns: data %b during home reset",
                                        $time, joy_data));
        release_all();
        joy_strobe = 1'b0;
        cycles = 0;
        while (sys_resetn !== 1'b1 && cycles < 3) begin
            @(negedge clk);
            cycles++;
        end
        assert (sys_resetn === 1'b1) else
            stop_with_failure("system reset did not return high within 3 cycles of release");
    endtask

    initial begin
        resetn     = 1'b0;
        joy_strobe = 1'b0;
        joy_clk    = 2'b00;
        release_all();
        build_table();
        repeat (5) @(negedge clk);
        resetn = 1'b1;
        check_reset_release();
        foreach (entries[i]) begin
            apply_entry(entries[i]);
            if (entries[i].autofire)
                check_autofire();
            else
                read_ports(entries[i]);
            release_all();
            @(negedge clk);
        end
        check_home_combo();
        $display("** PASS **");
        $finish;
    end

endmodule
